//--- tb.f
beam_pkg.sv
sync_fifo.sv
mem_streams.sv
frame_reader.sv
beam_mac.sv
beam_top.sv
beam_top_assertions.sv
tb_beam_top.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run for the beamformer testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

# Build
verilator --binary --timing --assert -f tb.f --top-module tb_beam_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Run and keep the output for the search below
./obj_dir/Vtb_beam_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "Test run failed"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

exit 0

//--- tb_beam_top.sv
`timescale 1ns/100ps

module tb_beam_top import beam_pkg::*; ();

    localparam int CHANNELS    = 4;
    localparam int NUM_BEAMS   = 2;
    localparam int FRAME_LEN   = 16;
    localparam int NUM_WTS     = NUM_BEAMS * CHANNELS;
    localparam int WT_ADDR_W   = $clog2(NUM_WTS);
    localparam int CLK_PERIOD  = 8;

    // Test lengths, also sizing the watchdog
    localparam int RAND_FRAMES = 4;
    localparam int GAP_FRAMES  = 3;
    localparam int MAX_GAP     = 3;
    localparam int OVF_LIMIT   = 400;
    localparam int DRAIN_LIMIT = 4 * FRAME_LEN + 20;
    localparam int ALL_FRAMES  = 1 + RAND_FRAMES + GAP_FRAMES;
    localparam int WATCHDOG_CYCLES = ALL_FRAMES * (FRAME_LEN * (MAX_GAP + 1) + 10)
                                     + OVF_LIMIT + 3 * DRAIN_LIMIT + 200;

    logic                   clk;
    logic                   reset;
    logic                   wr_wen;
    sample_t [CHANNELS-1:0] wr_data;
    logic                   wt_we;
    logic [WT_ADDR_W-1:0]   wt_addr;
    weight_t                wt_data;
    logic                   beam_valid;
    acc_t [NUM_BEAMS-1:0]   beam_sum;
    addr_t                  row_addr;
    logic                   overflow;

    // Rows written and still waiting for their sums
    sample_t [CHANNELS-1:0] row_q [$];
    addr_t                  addr_q [$];
    weight_t                wt_table [NUM_WTS];
    int                     wr_index;
    int                     results_seen;
    bit                     check_en;
    bit                     identity_mode;
    integer                 seed;

    beam_top #(
        .CHANNELS  (CHANNELS),
        .NUM_BEAMS (NUM_BEAMS),
        .FRAME_LEN (FRAME_LEN)
    ) DUT (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_wr_wen     (wr_wen),
        .i_wr_data    (wr_data),
        .i_wt_we      (wt_we),
        .i_wt_addr    (wt_addr),
        .i_wt_data    (wt_data),
        .o_beam_valid (beam_valid),
        .o_beam_sum   (beam_sum),
        .o_row_addr   (row_addr),
        .o_overflow   (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Reference and checking
    // ------------------------------

    // Weighted sum over channels for one beam
    function automatic acc_t beam_ref(input sample_t [CHANNELS-1:0] row, input int beam,
                                      input weight_t wts [NUM_WTS]);
        acc_t sum;
        sum = '0;
        for (int c = 0; c < CHANNELS; c++) begin
            sum = sum + acc_t'(row[c]) * acc_t'(wts[beam * CHANNELS + c]);
        end
        return sum;
    endfunction

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_value(input string name, input logic signed [63:0] actual,
                               input logic signed [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    // One queued row per result, in write order
    always @(negedge clk) begin : compare_results
        sample_t [CHANNELS-1:0] row;
        addr_t                  exp_addr;
        if (check_en && !reset) begin
            check_value("o_overflow", 64'(overflow), 64'(0));
            if (beam_valid) begin
                if (row_q.size() == 0) begin
                    $display("Beam result at %0t with no row written for it", $time);
                    stop_on_error();
                end else begin
                    row      = row_q.pop_front();
                    exp_addr = addr_q.pop_front();
                    for (int b = 0; b < NUM_BEAMS; b++) begin
                        check_value($sformatf("o_beam_sum[%0d]", b), 64'($signed(beam_sum[b])),
                                    64'(beam_ref(row, b, wt_table)));
                        // Identity weights pass the channel sample straight through
                        if (identity_mode) begin
                            check_value($sformatf("o_beam_sum[%0d]", b),
                                        64'($signed(beam_sum[b])), 64'($signed(row[b])));
                        end
                    end
                    check_value("o_row_addr", 64'(row_addr), 64'(exp_addr));
                    results_seen++;
                end
            end
        end
    end

    // Run time bound
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        stop_on_error();
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic apply_reset();
        reset  <= 1'b1;
        wr_wen <= 1'b0;
        wt_we  <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            wr_wen <= 1'b0;
        end
    endtask

    task automatic random_row(output sample_t [CHANNELS-1:0] row);
        for (int c = 0; c < CHANNELS; c++) begin
            row[c] = sample_t'($random(seed));
        end
    endtask

    // Expected row index counts up within a frame
    task automatic write_row(input sample_t [CHANNELS-1:0] row);
        @(posedge clk);
        wr_wen  <= 1'b1;
        wr_data <= row;
        row_q.push_back(row);
        addr_q.push_back(addr_t'(wr_index));
        wr_index = (wr_index + 1) % FRAME_LEN;
    endtask

    // Beam b sees weight 1 on channel b in identity mode
    task automatic load_weights(input bit identity);
        weight_t w;
        for (int i = 0; i < NUM_WTS; i++) begin
            if (identity) begin
                w = (i / CHANNELS == i % CHANNELS) ? weight_t'(1) : weight_t'(0);
            end else begin
                w = weight_t'($random(seed));
            end
            @(posedge clk);
            wt_we   <= 1'b1;
            wt_addr <= WT_ADDR_W'(i);
            wt_data <= w;
            wt_table[i] = w;
        end
        @(posedge clk);
        wt_we <= 1'b0;
    endtask

    task automatic write_frames(input int frames, input int max_gap);
        sample_t [CHANNELS-1:0] row;
        int                     gap;
        for (int i = 0; i < frames * FRAME_LEN; i++) begin
            random_row(row);
            write_row(row);
            if (max_gap > 0) begin
                gap = $unsigned($random(seed)) % (max_gap + 1);
                idle_cycles(gap);
            end
        end
        idle_cycles(1);
    endtask

    task automatic wait_for_results();
        int cycles;
        cycles = 0;
        while (row_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (row_q.size() != 0) begin
            $display("Timed out at %0t waiting for %0d beam results", $time, row_q.size());
            stop_on_error();
        end
    endtask

    // Back-to-back writes outrun the drain by two rows per frame
    task automatic flood_until_overflow();
        sample_t [CHANNELS-1:0] row;
        int                     writes;
        writes = 0;
        while (!overflow && writes < OVF_LIMIT) begin
            random_row(row);
            @(posedge clk);
            wr_wen  <= 1'b1;
            wr_data <= row;
            writes++;
            @(negedge clk);
        end
        idle_cycles(1);
        if (!overflow) begin
            $display("o_overflow never set after %0d back-to-back writes", writes);
            stop_on_error();
        end
        // Sticky while the backlog drains
        repeat (3 * FRAME_LEN) begin
            @(negedge clk);
            check_value("o_overflow", 64'(overflow), 64'(1));
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : run_tests
        sample_t [CHANNELS-1:0] row;
        int                     start_count;
        reset         = 1'b1;
        wr_wen        = 1'b0;
        wr_data       = '0;
        wt_we         = 1'b0;
        wt_addr       = '0;
        wt_data       = '0;
        seed          = 68;
        wr_index      = 0;
        results_seen  = 0;
        check_en      = 1'b0;
        identity_mode = 1'b0;
        apply_reset();
        @(negedge clk);
        check_value("o_beam_valid", 64'(beam_valid), 64'(0));
        check_value("o_overflow", 64'(overflow), 64'(0));
        check_en = 1'b1;

        // Partial frame holds, then identity frame
        load_weights(1'b1);
        identity_mode = 1'b1;
        for (int i = 0; i < FRAME_LEN - 1; i++) begin
            random_row(row);
            write_row(row);
        end
        idle_cycles(2 * FRAME_LEN);
        check_value("results before a full frame", 64'(results_seen), 64'(0));
        random_row(row);
        write_row(row);
        idle_cycles(1);
        wait_for_results();
        check_value("identity result count", 64'(results_seen), 64'(FRAME_LEN));
        identity_mode = 1'b0;

        // Random weights, back-to-back frames
        load_weights(1'b0);
        start_count = results_seen;
        write_frames(RAND_FRAMES, 0);
        wait_for_results();
        check_value("random result count", 64'(results_seen - start_count),
                    64'(RAND_FRAMES * FRAME_LEN));

        // Idle gaps between writes
        load_weights(1'b0);
        start_count = results_seen;
        write_frames(GAP_FRAMES, MAX_GAP);
        wait_for_results();
        check_value("gapped result count", 64'(results_seen - start_count),
                    64'(GAP_FRAMES * FRAME_LEN));

        // Overflow, cleared only by reset
        check_en = 1'b0;
        flood_until_overflow();
        @(posedge clk);
        apply_reset();
        @(negedge clk);
        check_value("o_overflow", 64'(overflow), 64'(0));
        check_value("o_beam_valid", 64'(beam_valid), 64'(0));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- beam_top_assertions.sv
`timescale 1ns/100ps

module beam_top_assertions #(
    parameter bit CHECK_READER = 1'b0,
    parameter bit CHECK_BANK   = 1'b0
) (
    input logic i_clk,
    input logic i_reset,
    input logic i_rd_ren,
    input logic i_drain,
    input logic i_head_valid,
    input logic i_tvalid
);

    // Sequencer side
    if (CHECK_READER) begin : g_reader
        // Reads belong to DRAIN, at most one frame of them
        a_ren_in_drain: assert property (@(posedge i_clk) disable iff (i_reset)
            i_rd_ren |-> i_drain)
            else $error("rd_ren high outside the DRAIN read window");
    end

    // FIFO bank side
    if (CHECK_BANK) begin : g_bank
        // Never pop an empty head
        a_ren_head_valid: assert property (@(posedge i_clk) disable iff (i_reset)
            i_rd_ren |-> i_head_valid)
            else $error("read issued with no valid head");

        // tvalid exactly one cycle after each read
        a_tvalid_follows: assert property (@(posedge i_clk) disable iff (i_reset)
            i_tvalid == $past(i_rd_ren))
            else $error("tvalid does not follow rd_ren by one cycle");
    end

endmodule

// Sequencer side
bind frame_reader beam_top_assertions #(
    .CHECK_READER (1'b1),
    .CHECK_BANK   (1'b0)
) u_reader_checks (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_rd_ren     (o_rd_ren),
    .i_drain      ((state == DRAIN) && (int'(drain_cnt) < FRAME_LEN)),
    .i_head_valid (1'b0),
    .i_tvalid     (1'b0)
);

// FIFO bank side
bind mem_streams beam_top_assertions #(
    .CHECK_READER (1'b0),
    .CHECK_BANK   (1'b1)
) u_fifo_bank_checks (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_rd_ren     (i_rd_ren),
    .i_drain      (1'b0),
    .i_head_valid (o_head_valid),
    .i_tvalid     (o_tvalid)
);

//--- beam_top.sv
`timescale 1ns/100ps

module beam_top import beam_pkg::*; #(
    parameter int CHANNELS  = 4,
    parameter int NUM_BEAMS = 2,
    parameter int FRAME_LEN = 16
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset,

    // Sample writer, one row per strobe
    input  logic                                    i_wr_wen,
    input  sample_t [CHANNELS-1:0]                  i_wr_data,

    // Weight load port
    input  logic                                    i_wt_we,
    input  logic [$clog2(NUM_BEAMS*CHANNELS)-1:0]   i_wt_addr,
    input  weight_t                                 i_wt_data,

    // Beam results, no back-pressure
    output logic                                    o_beam_valid,
    output acc_t    [NUM_BEAMS-1:0]                 o_beam_sum,
    output addr_t                                   o_row_addr,
    output logic                                    o_overflow
);

    // ------------------------------
    // Internal wires
    // ------------------------------
    logic                   rd_ren;
    logic                   head_valid;
    logic                   tvalid;
    sample_t [CHANNELS-1:0] rd_data;
    addr_t                  rd_addr;

    // FIFO bank
    mem_streams #(
        .CHANNELS  (CHANNELS),
        .FRAME_LEN (FRAME_LEN)
    ) u_mem_streams (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wr_wen     (i_wr_wen),
        .i_wr_data    (i_wr_data),
        .i_rd_ren     (rd_ren),
        .o_rd_data    (rd_data),
        .o_rd_addr    (rd_addr),
        .o_tvalid     (tvalid),
        .o_head_valid (head_valid),
        .o_overflow   (o_overflow)
    );

    // Drain sequencer
    frame_reader #(
        .FRAME_LEN (FRAME_LEN)
    ) u_frame_reader (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wr_wen     (i_wr_wen),
        .i_head_valid (head_valid),
        .o_rd_ren     (rd_ren)
    );

    // Weighted sums
    beam_mac #(
        .CHANNELS  (CHANNELS),
        .NUM_BEAMS (NUM_BEAMS)
    ) u_beam_mac (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wt_we      (i_wt_we),
        .i_wt_addr    (i_wt_addr),
        .i_wt_data    (i_wt_data),
        .i_tvalid     (tvalid),
        .i_samples    (rd_data),
        .i_row_addr   (rd_addr),
        .o_beam_valid (o_beam_valid),
        .o_beam_sum   (o_beam_sum),
        .o_row_addr   (o_row_addr)
    );

endmodule

//--- beam_mac.sv
`timescale 1ns/100ps

module beam_mac import beam_pkg::*; #(
    parameter int CHANNELS  = 4,
    parameter int NUM_BEAMS = 2
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset,

    // Weight load, address is beam * CHANNELS + channel
    input  logic                                    i_wt_we,
    input  logic [$clog2(NUM_BEAMS*CHANNELS)-1:0]   i_wt_addr,
    input  weight_t                                 i_wt_data,

    // One row of samples per tvalid pulse
    input  logic                                    i_tvalid,
    input  sample_t [CHANNELS-1:0]                  i_samples,
    input  addr_t                                   i_row_addr,

    // One sum per beam, two cycles after tvalid
    output logic                                    o_beam_valid,
    output acc_t    [NUM_BEAMS-1:0]                 o_beam_sum,
    output addr_t                                   o_row_addr
);

    localparam int NUM_WTS = NUM_BEAMS * CHANNELS;
    localparam int PROD_W  = $bits(sample_t) + $bits(weight_t);

    // ------------------------------
    // Weight bank
    // ------------------------------
    weight_t wts [NUM_WTS];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_WTS; i++) begin
                wts[i] <= '0;
            end
        end else if (i_wt_we && (int'(i_wt_addr) < NUM_WTS)) begin
            wts[i_wt_addr] <= i_wt_data;
        end
    end

    // ------------------------------
    // Stage 1, products
    // ------------------------------
    logic signed [PROD_W-1:0] prod [NUM_BEAMS][CHANNELS];
    logic                     valid_s1;
    addr_t                    addr_s1;

    always_ff @(posedge i_clk) begin
        if (i_tvalid) begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                for (int c = 0; c < CHANNELS; c++) begin
                    prod[b][c] <= $signed(i_samples[c]) * wts[b*CHANNELS + c];
                end
            end
            addr_s1 <= i_row_addr;
        end
    end

    // ------------------------------
    // Stage 2, per-beam sums
    // ------------------------------
    acc_t beam_acc [NUM_BEAMS];

    // Sign-extended adder tree over the channels
    always_comb begin
        for (int b = 0; b < NUM_BEAMS; b++) begin
            beam_acc[b] = '0;
            for (int c = 0; c < CHANNELS; c++) begin
                beam_acc[b] = beam_acc[b] + acc_t'(prod[b][c]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (valid_s1) begin
            for (int b = 0; b < NUM_BEAMS; b++) begin
                o_beam_sum[b] <= beam_acc[b];
            end
            // Row index travels with its sums
            o_row_addr <= addr_s1;
        end
    end

    // Valid pipeline
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_s1     <= 1'b0;
            o_beam_valid <= 1'b0;
        end else begin
            valid_s1     <= i_tvalid;
            o_beam_valid <= valid_s1;
        end
    end

endmodule

//--- frame_reader.sv
`timescale 1ns/100ps

module frame_reader import beam_pkg::*; #(
    parameter int FRAME_LEN = 16
) (
    input  logic i_clk,
    input  logic i_reset,

    // Write strobe, counted as rows arrive
    input  logic i_wr_wen,

    // Head of the FIFO bank holds a row
    input  logic i_head_valid,
    output logic o_rd_ren
);

    // One bit wider than addr_t to hold a full FIFO's worth
    localparam int CNT_W = $bits(addr_t) + 1;

    rd_state_t        state;
    logic [CNT_W-1:0] fill_cnt;
    addr_t            drain_cnt;

    logic frame_ready;
    logic last_read;

    // ------------------------------
    // Strobes and conditions
    // ------------------------------

    // Whole frame buffered
    assign frame_ready = (fill_cnt >= CNT_W'(FRAME_LEN));

    // Read only while draining and only a valid head
    assign o_rd_ren = (state == DRAIN) && i_head_valid;

    // Final row of the frame
    assign last_read = o_rd_ren && (drain_cnt == addr_t'(FRAME_LEN - 1));

    // ------------------------------
    // Sequencer
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= FILL;
            fill_cnt  <= '0;
            drain_cnt <= '0;
        end else begin
            // Fill count keeps running in every state
            // Rows of the next frame can arrive during DRAIN and DONE
            if (state == FILL && frame_ready) begin
                // Hand one frame to the drain side
                fill_cnt <= fill_cnt - CNT_W'(FRAME_LEN) + CNT_W'(i_wr_wen);
            end else if (i_wr_wen) begin
                fill_cnt <= fill_cnt + 1'b1;
            end

            case (state)
                FILL: begin
                    if (frame_ready) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (o_rd_ren) begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                    if (last_read) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    // Ready for the next frame
                    drain_cnt <= '0;
                    state     <= FILL;
                end
                default: begin
                    state <= FILL;
                end
            endcase
        end
    end

endmodule

//--- mem_streams.sv
`timescale 1ns/100ps

module mem_streams import beam_pkg::*; #(
    parameter int CHANNELS  = 4,
    parameter int FRAME_LEN = 16
) (
    input  logic                   i_clk,
    input  logic                   i_reset,

    // Write side, one row per strobe
    input  logic                   i_wr_wen,
    input  sample_t [CHANNELS-1:0] i_wr_data,

    // Read side, all channels in lockstep
    input  logic                   i_rd_ren,
    output sample_t [CHANNELS-1:0] o_rd_data,
    output addr_t                  o_rd_addr,
    output logic                   o_tvalid,
    output logic                   o_head_valid,

    // Sticky, set by a write into a full FIFO
    output logic                   o_overflow
);

    // ------------------------------
    // Write fan-out register
    // ------------------------------
    logic                   wr_wen_r;
    sample_t [CHANNELS-1:0] wr_data_r;

    // FIFO bank outputs
    sample_t                fifo_dout [CHANNELS];
    logic    [CHANNELS-1:0] fifo_valid;
    logic    [CHANNELS-1:0] fifo_full;

    // Read bookkeeping
    logic                   pop;
    addr_t                  rd_cnt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_wen_r <= 1'b0;
        end else begin
            wr_wen_r <= i_wr_wen;
        end
    end

    // Payload only, qualified by wr_wen_r
    always_ff @(posedge i_clk) begin
        wr_data_r <= i_wr_data;
    end

    // ------------------------------
    // One FIFO per channel
    // ------------------------------
    for (genvar gi = 0; gi < CHANNELS; gi++) begin : g_fifo
        sync_fifo u_fifo (
            .i_clk   (i_clk),
            .i_reset (i_reset),
            .i_wr_en (wr_wen_r),
            .i_din   (wr_data_r[gi]),
            .i_rd_en (pop),
            .o_dout  (fifo_dout[gi]),
            .o_valid (fifo_valid[gi]),
            .o_empty (),
            .o_full  (fifo_full[gi])
        );
    end

    // All channels are written together, so their heads line up
    assign o_head_valid = &fifo_valid;

    // Pop only a valid head
    assign pop = i_rd_ren && o_head_valid;

    // ------------------------------
    // Registered read
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tvalid <= 1'b0;
            rd_cnt   <= '0;
        end else begin
            o_tvalid <= pop;
            if (pop) begin
                // Row index wraps at the end of each frame
                if (rd_cnt == addr_t'(FRAME_LEN - 1)) begin
                    rd_cnt <= '0;
                end else begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
            end
        end
    end

    // Row data and index, valid with o_tvalid
    always_ff @(posedge i_clk) begin
        if (pop) begin
            for (int ch = 0; ch < CHANNELS; ch++) begin
                o_rd_data[ch] <= fifo_dout[ch];
            end
            o_rd_addr <= rd_cnt;
        end
    end

    // Overflow from channel 0, the others see the same writes
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_overflow <= 1'b0;
        end else if (wr_wen_r && fifo_full[0]) begin
            o_overflow <= 1'b1;
        end
    end

endmodule

//--- sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo import beam_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,

    // Write side
    input  logic    i_wr_en,
    input  sample_t i_din,

    // Read side, head word always on o_dout
    input  logic    i_rd_en,
    output sample_t o_dout,
    output logic    o_valid,
    output logic    o_empty,
    output logic    o_full
);

    // Depth follows from the pointer width
    localparam int DEPTH = 2 ** $bits(addr_t);
    localparam int CNT_W = $bits(addr_t) + 1;

    // ------------------------------
    // Storage and pointers
    // ------------------------------
    sample_t          mem [DEPTH];
    addr_t            wr_ptr;
    addr_t            rd_ptr;
    logic [CNT_W-1:0] count;

    logic wr_ok;
    logic rd_ok;

    // Writes into a full FIFO are dropped
    assign wr_ok = i_wr_en && !o_full;
    // Reads from an empty FIFO do nothing
    assign rd_ok = i_rd_en && !o_empty;

    // Flags straight from the occupancy count
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_valid = !o_empty;

    // First word fall through
    assign o_dout = mem[rd_ptr];

    // Word store
    always_ff @(posedge i_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_din;
        end
    end

    // Pointers wrap on their own at DEPTH
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count unchanged on a simultaneous read and write
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- beam_pkg.sv
package beam_pkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------

    // One signed channel sample
    typedef logic signed [15:0] sample_t;

    // One signed beam weight
    typedef logic signed [15:0] weight_t;

    // Beam sum
    // 32 bits of product plus 2 bits of growth for four channels
    typedef logic signed [33:0] acc_t;

    // FIFO word address or word count
    // Also sets the FIFO depth, 32 words
    typedef logic [4:0] addr_t;

    // ------------------------------
    // Read sequencer
    // ------------------------------

    // FILL   waiting for a whole frame to be stored
    // DRAIN  reading the frame out in lockstep
    // DONE   one cycle to clear the drain count
    typedef enum logic [1:0] {
        FILL  = 2'd0,
        DRAIN = 2'd1,
        DONE  = 2'd2
    } rd_state_t;

endpackage
